//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width of the integer lanes.
`define XLEN 32

// Architectural register count, x0 included.
`define NUM_REGS 32

`define PAIR_QUEUE_DEPTH 4  // Also the fetch side's starting credit count.

`define OUT_CREDITS 4       // Result credits held by the sender after reset.

`endif

//--- isa_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package isa_pkg;

  typedef logic [4:0] reg_addr_t;

  // Major opcodes of the supported integer subset.
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD = 3'b000;  // ADD, SUB and ADDI.
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;  // Selects SUB over ADD.

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // One instruction word, seen as register or immediate format.
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_word_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef struct packed {
    alu_op_t          alu_op;
    reg_addr_t        rd;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic             use_rs2;  // Low for the immediate forms.
    logic [`XLEN-1:0] imm;
  } decoded_t;

endpackage

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package pipe_pkg;

  // One issued instruction with its operands already resolved.
  typedef struct packed {
    logic               valid;
    isa_pkg::alu_op_t   alu_op;
    isa_pkg::reg_addr_t rd;
    logic [`XLEN-1:0]   operand_a;
    logic [`XLEN-1:0]   operand_b;
  } lane_t;

  // A retired instruction as written back and reported.
  typedef struct packed {
    logic               valid;
    isa_pkg::reg_addr_t rd;
    logic [`XLEN-1:0]   data;
  } result_t;

endpackage

`default_nettype wire

//--- issue_lane_if.sv
`default_nettype none

// The two lanes leaving the issue stage.
interface issue_lane_if;

  pipe_pkg::lane_t lane0;  // Older instruction when both lanes are valid.
  pipe_pkg::lane_t lane1;

  modport issue (
    output lane0,
    output lane1
  );

  modport exec (
    input lane0,
    input lane1
  );

endinterface

`default_nettype wire

//--- pair_queue.sv
`default_nettype none

`include "core_cfg.svh"

module pair_queue (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid,
  input  isa_pkg::instr_word_t in_instr0,
  input  isa_pkg::instr_word_t in_instr1,
  input  logic                 pop,
  output logic                 head_valid,
  output isa_pkg::instr_word_t head_instr0,
  output isa_pkg::instr_word_t head_instr1,
  output logic                 in_credit
);

  localparam int PTR_W = $clog2(`PAIR_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`PAIR_QUEUE_DEPTH + 1);

  isa_pkg::instr_word_t slot0_mem [`PAIR_QUEUE_DEPTH];
  isa_pkg::instr_word_t slot1_mem [`PAIR_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] occupancy;
  logic             pop_fire;

  assign head_valid  = (occupancy != '0);
  assign head_instr0 = slot0_mem[rd_ptr];
  assign head_instr1 = slot1_mem[rd_ptr];
  assign pop_fire    = pop && head_valid;

  // The fetch side only pushes while it holds a credit, so a push never meets a full queue.
  always_ff @(posedge clock) begin
    if (in_valid) begin
      slot0_mem[wr_ptr] <= in_instr0;
      slot1_mem[wr_ptr] <= in_instr1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`PAIR_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(`PAIR_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      occupancy <= occupancy + CNT_W'(in_valid) - CNT_W'(pop_fire);
      in_credit <= pop_fire;  // One slot freed, one credit back.
    end
  end

endmodule

`default_nettype wire

//--- issue_stage.sv
`default_nettype none

`include "core_cfg.svh"

module issue_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          head_valid,
  input  isa_pkg::instr_word_t          head_instr0,
  input  isa_pkg::instr_word_t          head_instr1,
  output logic                          pop,
  input  logic                          credit_avail,
  output isa_pkg::reg_addr_t [3:0]      rd_addr,
  input  logic [3:0][`XLEN-1:0]         rd_data,
  input  pipe_pkg::result_t             wb0,
  input  pipe_pkg::result_t             wb1,
  issue_lane_if.issue                   lanes
);

  // ==========================================================================
  // Decode
  // ==========================================================================

  function automatic isa_pkg::decoded_t decode(isa_pkg::instr_word_t w);
    isa_pkg::decoded_t d;
    d.use_rs2 = (w.r.opcode == isa_pkg::OPC_REG);
    d.rd      = w.r.rd;
    d.rs1     = w.r.rs1;
    d.rs2     = d.use_rs2 ? w.r.rs2 : '0;
    d.imm     = {{(`XLEN - 12){w.i.imm[11]}}, w.i.imm};
    case (w.r.funct3)
      isa_pkg::F3_ADD: begin
        d.alu_op = (d.use_rs2 && w.r.funct7 == isa_pkg::F7_SUB) ? isa_pkg::ALU_SUB
                                                                : isa_pkg::ALU_ADD;
      end
      isa_pkg::F3_XOR: d.alu_op = isa_pkg::ALU_XOR;
      isa_pkg::F3_OR:  d.alu_op = isa_pkg::ALU_OR;
      default:         d.alu_op = isa_pkg::ALU_AND;
    endcase
    return d;
  endfunction

  function automatic logic reads_reg(isa_pkg::decoded_t d, isa_pkg::reg_addr_t r);
    return (r != '0) && (d.rs1 == r || (d.use_rs2 && d.rs2 == r));
  endfunction

  // Youngest write-back wins.
  function automatic logic [`XLEN-1:0] forward(isa_pkg::reg_addr_t addr,
                                               logic [`XLEN-1:0] rf_value,
                                               pipe_pkg::result_t w0,
                                               pipe_pkg::result_t w1);
    logic [`XLEN-1:0] value;
    value = rf_value;
    if (w0.valid && w0.rd == addr && addr != '0)
      value = w0.data;
    if (w1.valid && w1.rd == addr && addr != '0)
      value = w1.data;
    return value;
  endfunction

  function automatic pipe_pkg::lane_t build_lane(isa_pkg::decoded_t d,
                                                 logic [`XLEN-1:0] a_value,
                                                 logic [`XLEN-1:0] b_value);
    pipe_pkg::lane_t l;
    l.valid     = 1'b0;
    l.alu_op    = d.alu_op;
    l.rd        = d.rd;
    l.operand_a = a_value;
    l.operand_b = d.use_rs2 ? b_value : d.imm;
    return l;
  endfunction

  isa_pkg::decoded_t dec0, dec1, slot_a;
  pipe_pkg::lane_t   lane0_q, lane1_q, lane0_d, lane1_d;
  logic              half_done;  // Slot 0 of the head pair already went out.
  logic              conflict, raw_hold, go;

  assign dec0   = decode(head_instr0);
  assign dec1   = decode(head_instr1);
  assign slot_a = half_done ? dec1 : dec0;

  // ==========================================================================
  // Hazards
  // ==========================================================================

  function automatic logic in_flight(isa_pkg::decoded_t d, pipe_pkg::lane_t l0,
                                     pipe_pkg::lane_t l1);
    return (l0.valid && reads_reg(d, l0.rd)) || (l1.valid && reads_reg(d, l1.rd));
  endfunction

  assign conflict = (dec0.rd != '0) && (reads_reg(dec1, dec0.rd) || dec1.rd == dec0.rd);

  // A source still in the lanes has no value yet. Wait one cycle and take it from wb.
  assign raw_hold = half_done ? in_flight(dec1, lane0_q, lane1_q)
                              : (in_flight(dec0, lane0_q, lane1_q) ||
                                 (!conflict && in_flight(dec1, lane0_q, lane1_q)));

  assign go  = head_valid && credit_avail && !raw_hold;
  assign pop = go && (half_done || !conflict);

  // ==========================================================================
  // Operands and lane registers
  // ==========================================================================

  assign rd_addr[0] = slot_a.rs1;
  assign rd_addr[1] = slot_a.rs2;
  assign rd_addr[2] = dec1.rs1;
  assign rd_addr[3] = dec1.rs2;

  always_comb begin
    lane0_d = build_lane(slot_a, forward(rd_addr[0], rd_data[0], wb0, wb1),
                         forward(rd_addr[1], rd_data[1], wb0, wb1));
    lane1_d = build_lane(dec1, forward(rd_addr[2], rd_data[2], wb0, wb1),
                         forward(rd_addr[3], rd_data[3], wb0, wb1));
    lane0_d.valid = go;
    lane1_d.valid = go && !half_done && !conflict;
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      half_done     <= 1'b0;
      lane0_q.valid <= 1'b0;
      lane1_q.valid <= 1'b0;
    end else begin
      if (go) begin
        half_done <= !half_done && conflict;
      end
      lane0_q <= lane0_d;
      lane1_q <= lane1_d;
    end
  end

  assign lanes.lane0 = lane0_q;
  assign lanes.lane1 = lane1_q;

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

`include "core_cfg.svh"

module register_file (
  input  logic                     clock,
  input  logic                     reset,
  input  isa_pkg::reg_addr_t [3:0] rd_addr,
  output logic [3:0][`XLEN-1:0]    rd_data,
  input  pipe_pkg::result_t        wb0,
  input  pipe_pkg::result_t        wb1
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rd_data[p] = (rd_addr[p] == '0) ? '0 : regs[rd_addr[p]];
    end
  end

  // Lane 1 is the younger write, so it lands last.
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int r = 0; r < `NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wb0.valid && wb0.rd != '0) begin
        regs[wb0.rd] <= wb0.data;
      end
      if (wb1.valid && wb1.rd != '0) begin
        regs[wb1.rd] <= wb1.data;
      end
    end
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

`include "core_cfg.svh"

module execute_stage (
  input  logic              clock,
  input  logic              reset,
  issue_lane_if.exec        lanes,
  output pipe_pkg::result_t wb0,
  output pipe_pkg::result_t wb1
);

  // ==========================================================================
  // ALU
  // ==========================================================================

  function automatic logic [`XLEN-1:0] alu(isa_pkg::alu_op_t op,
                                           logic [`XLEN-1:0] a,
                                           logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] y;
    case (op)
      isa_pkg::ALU_ADD: y = a + b;
      isa_pkg::ALU_SUB: y = a - b;
      isa_pkg::ALU_AND: y = a & b;
      isa_pkg::ALU_OR:  y = a | b;
      default:          y = a ^ b;
    endcase
    return y;
  endfunction

  logic [`XLEN-1:0] alu0_y, alu1_y;

  assign alu0_y = alu(lanes.lane0.alu_op, lanes.lane0.operand_a, lanes.lane0.operand_b);
  assign alu1_y = alu(lanes.lane1.alu_op, lanes.lane1.operand_a, lanes.lane1.operand_b);

  // ==========================================================================
  // Result register
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wb0.valid <= 1'b0;
      wb1.valid <= 1'b0;
    end else begin
      wb0.valid <= lanes.lane0.valid;
      wb1.valid <= lanes.lane1.valid;
    end
  end

  // x0 destinations retire with zero data.
  always_ff @(posedge clock) begin
    wb0.rd   <= lanes.lane0.rd;
    wb0.data <= (lanes.lane0.rd == '0) ? '0 : alu0_y;
    wb1.rd   <= lanes.lane1.rd;
    wb1.data <= (lanes.lane1.rd == '0) ? '0 : alu1_y;
  end

endmodule

`default_nettype wire

//--- result_sender.sv
`default_nettype none

`include "core_cfg.svh"

module result_sender (
  input  logic               clock,
  input  logic               reset,
  issue_lane_if.exec         lanes,
  input  pipe_pkg::result_t  wb0,
  input  pipe_pkg::result_t  wb1,
  input  logic               res_credit,
  output logic               credit_avail,
  output logic               res_valid0,
  output isa_pkg::reg_addr_t res_rd0,
  output logic [`XLEN-1:0]   res_data0,
  output logic               res_valid1,
  output isa_pkg::reg_addr_t res_rd1,
  output logic [`XLEN-1:0]   res_data1
);

  localparam int CNT_W = $clog2(`OUT_CREDITS + 1);

  logic [CNT_W-1:0] credit_count;
  logic [CNT_W-1:0] unreserved;
  logic [1:0]       lane_cnt;

  assign lane_cnt = {1'b0, lanes.lane0.valid} + {1'b0, lanes.lane1.valid};

  // Lanes on the bus hold their credits this cycle already.
  assign unreserved   = credit_count - CNT_W'(lane_cnt);
  assign credit_avail = (unreserved >= CNT_W'(2));

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      credit_count <= CNT_W'(`OUT_CREDITS);
    end else begin
      credit_count <= unreserved + CNT_W'(res_credit);
    end
  end

  assign res_valid0 = wb0.valid;
  assign res_rd0    = wb0.rd;
  assign res_data0  = wb0.data;
  assign res_valid1 = wb1.valid;
  assign res_rd1    = wb1.rd;
  assign res_data1  = wb1.data;

endmodule

`default_nettype wire

//--- issue_core.sv
`default_nettype none

`include "core_cfg.svh"

module issue_core (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  logic [31:0]      in_instr0,
  input  logic [31:0]      in_instr1,
  output logic             in_credit,
  output logic             res_valid0,
  output logic [4:0]       res_rd0,
  output logic [`XLEN-1:0] res_data0,
  output logic             res_valid1,
  output logic [4:0]       res_rd1,
  output logic [`XLEN-1:0] res_data1,
  input  logic             res_credit
);

  logic                     head_valid;
  isa_pkg::instr_word_t     head_instr0, head_instr1;
  logic                     pop;
  logic                     credit_avail;
  isa_pkg::reg_addr_t [3:0] rd_addr;
  logic [3:0][`XLEN-1:0]    rd_data;
  pipe_pkg::result_t        wb0, wb1;

  issue_lane_if lanes_if ();

  pair_queue pair_queue_i (
    .clock, .reset, .in_valid, .in_instr0, .in_instr1, .pop,
    .head_valid, .head_instr0, .head_instr1, .in_credit
  );

  issue_stage issue_stage_i (
    .clock, .reset, .head_valid, .head_instr0, .head_instr1, .pop,
    .credit_avail, .rd_addr, .rd_data, .wb0, .wb1, .lanes(lanes_if.issue)
  );

  register_file register_file_i (
    .clock, .reset, .rd_addr, .rd_data, .wb0, .wb1
  );

  execute_stage execute_stage_i (
    .clock, .reset, .lanes(lanes_if.exec), .wb0, .wb1
  );

  result_sender result_sender_i (
    .clock, .reset, .lanes(lanes_if.exec), .wb0, .wb1, .res_credit, .credit_avail,
    .res_valid0, .res_rd0, .res_data0, .res_valid1, .res_rd1, .res_data1
  );

endmodule

`default_nettype wire

//--- issue_core_chk.sv
`default_nettype none

`include "core_cfg.svh"

module issue_core_chk (
  input logic                                    clock,
  input logic                                    reset,
  input logic                                    in_credit,
  input logic                                    res_valid0,
  input logic                                    res_valid1,
  input logic [$clog2(`PAIR_QUEUE_DEPTH + 1)-1:0] queue_count,
  input logic [$clog2(`OUT_CREDITS + 1)-1:0]      credit_count
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int QCNT_W = $clog2(`PAIR_QUEUE_DEPTH + 1);
  localparam int CCNT_W = $clog2(`OUT_CREDITS + 1);

  queue_bound: assert property (@(posedge clock) disable iff (reset == 1'b0)
    queue_count <= QCNT_W'(`PAIR_QUEUE_DEPTH))
    else $error("Pair queue holds %0d pairs, more than its depth.", queue_count);

  lane_order: assert property (@(posedge clock) disable iff (reset == 1'b0)
    res_valid1 |-> res_valid0)
    else $error("Result lane 1 is valid while lane 0 is idle.");

  // A counter that went below zero wraps to a value above the limit.
  credit_bound: assert property (@(posedge clock) disable iff (reset == 1'b0)
    credit_count <= CCNT_W'(`OUT_CREDITS))
    else $error("Output credit counter out of range at %0d.", credit_count);

  quiet_in_reset: assert property (@(posedge clock)
    (reset == 1'b0 && $past(reset) == 1'b0) |-> !(in_credit || res_valid0 || res_valid1))
    else $error("Credit or result valid is high while reset is held.");

endmodule

bind issue_core issue_core_chk chk_i (
  .clock,
  .reset,
  .in_credit,
  .res_valid0,
  .res_valid1,
  .queue_count(pair_queue_i.occupancy),
  .credit_count(result_sender_i.credit_count)
);

`default_nettype wire

//--- issue_core_tb.sv
`default_nettype none

`include "core_cfg.svh"

module issue_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic clock, reset, in_valid, in_credit, res_credit;
  logic [31:0] in_instr0, in_instr1;
  logic res_valid0, res_valid1;
  logic [4:0] res_rd0, res_rd1;
  logic [`XLEN-1:0] res_data0, res_data1;

  logic [31:0] seed = 32'hc65e_cd8e;
  logic [`XLEN-1:0] model_regs [`NUM_REGS];
  logic [36:0] exp_q [$];  // Expected {rd, data} in program order.
  string test_name = "reset";
  int checks, mismatches, other_errors, cycles, instrs_sent, pairs_sent;
  int fetch_credits, credit_pulses, outstanding, results_total, returned_total;
  logic hold_credits;

  issue_core dut_i (
    .clock, .reset, .in_valid, .in_instr0, .in_instr1, .in_credit,
    .res_valid0, .res_rd0, .res_data0, .res_valid1, .res_rd1, .res_data1, .res_credit
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // ==========================================================================
  // Reference model and stimulus helpers
  // ==========================================================================

  function automatic logic [36:0] ref_exec(input logic [31:0] w);
    logic [4:0] rd;
    logic [`XLEN-1:0] a, b, y;
    logic reg_form;
    reg_form = (w[6:0] == 7'b0110011);
    rd = w[11:7];
    a = model_regs[w[19:15]];
    b = reg_form ? model_regs[w[24:20]] : {{(`XLEN - 12){w[31]}}, w[31:20]};
    case (w[14:12])
      3'b000:  y = (reg_form && w[30]) ? a - b : a + b;  // Bit 30 marks SUB.
      3'b100:  y = a ^ b;
      3'b110:  y = a | b;
      default: y = a & b;
    endcase
    if (rd == 5'd0) y = '0;
    else model_regs[rd] = y;
    return {rd, y};
  endfunction

  function automatic logic [31:0] rand_instr(input int lo, input int hi);
    int span, kind;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    span = hi - lo + 1;
    kind = $unsigned($random(seed)) % 9;
    rd = 5'(lo + $unsigned($random(seed)) % span);
    rs1 = 5'(lo + $unsigned($random(seed)) % span);
    rs2 = 5'(lo + $unsigned($random(seed)) % span);
    case (kind)
      0, 1, 5: f3 = 3'b000;
      2, 6:    f3 = 3'b111;
      3, 7:    f3 = 3'b110;
      default: f3 = 3'b100;
    endcase
    if (kind < 5)
      return {(kind == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    return {12'($random(seed)), rs1, f3, rd, 7'b0010011};
  endfunction

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      mismatches++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Each falling edge takes back fetch credits, pays out consumer credits and drops in_valid.
  task automatic cycle_step();
    @(negedge clock);
    in_valid = 1'b0;
    if (in_credit) begin
      fetch_credits++;
      credit_pulses++;
    end
    outstanding += int'(res_valid0) + int'(res_valid1);
    results_total += int'(res_valid0) + int'(res_valid1);
    check("credit_bound", 64'd1, 64'(results_total <= `OUT_CREDITS + returned_total));
    res_credit = 1'b0;
    if (!hold_credits && outstanding > 0 && ($random(seed) & 3) != 0) begin
      res_credit = 1'b1;
      outstanding--;
      returned_total++;
    end
  endtask

  task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
    do cycle_step(); while (fetch_credits == 0);
    in_valid = 1'b1;
    in_instr0 = w0;
    in_instr1 = w1;
    fetch_credits--;
    pairs_sent++;
    instrs_sent += 2;
    exp_q.push_back(ref_exec(w0));
    exp_q.push_back(ref_exec(w1));
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || fetch_credits != `PAIR_QUEUE_DEPTH || outstanding != 0)
      cycle_step();
  endtask

  task automatic report_counts();
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
  endtask

  // ==========================================================================
  // Comparison and timeout
  // ==========================================================================

  task automatic compare_lane(input logic [4:0] rd, input logic [`XLEN-1:0] data);
    logic [36:0] e;
    if (exp_q.size() == 0) begin
      other_errors++;
      $display("Result for x%0d arrived with no instruction outstanding", rd);
    end else begin
      e = exp_q.pop_front();
      check("rd", 64'(e[36:32]), 64'(rd));
      check("data", 64'(e[31:0]), 64'(data));
    end
  endtask

  always @(negedge clock) begin
    if (res_valid0) compare_lane(res_rd0, res_data0);  // Lane 0 is older.
    if (res_valid1) compare_lane(res_rd1, res_data1);
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > 40 * instrs_sent + 200) begin
      $display("Timeout after %0d cycles with %0d results still expected",
               cycles, exp_q.size());
      report_counts();
      $display("** FAIL **");
      $finish;
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    logic [31:0] w0, w1;
    logic [4:0] prev_rd1;
    reset = 1'b0;
    in_valid = 1'b0;
    in_instr0 = '0;
    in_instr1 = '0;
    res_credit = 1'b0;
    hold_credits = 1'b0;
    fetch_credits = `PAIR_QUEUE_DEPTH;
    for (int r = 0; r < `NUM_REGS; r++) model_regs[r] = '0;
    repeat (5) @(negedge clock);
    reset = 1'b1;
    repeat (3) cycle_step();
    check("idle", 64'd0, 64'({res_valid0, res_valid1, in_credit}));

    test_name = "independent";  // rand_instr(0, 15) also covers x0.
    for (int n = 0; n < 8; n++) send_pair(rand_instr(0, 15), rand_instr(16, 31));
    drain();

    test_name = "split";
    for (int n = 0; n < 8; n++) begin
      w0 = rand_instr(1, 7);
      w1 = rand_instr(1, 7);
      if (n % 2 == 0) w1[19:15] = w0[11:7];
      else w1[11:7] = w0[11:7];
      send_pair(w0, w1);
    end
    drain();

    test_name = "forward";
    prev_rd1 = 5'd16;
    for (int n = 0; n < 10; n++) begin
      w0 = rand_instr(8, 15);
      w1 = rand_instr(16, 23);
      w0[19:15] = prev_rd1;
      w1[19:15] = prev_rd1;
      prev_rd1 = w1[11:7];
      send_pair(w0, w1);
    end
    drain();

    test_name = "backpressure";
    hold_credits = 1'b1;
    for (int n = 0; n < 5; n++) send_pair(rand_instr(0, 15), rand_instr(16, 31));
    repeat (20) cycle_step();
    check("stalled", 64'd1, 64'(exp_q.size() >= 10 - `OUT_CREDITS));
    hold_credits = 1'b0;
    drain();

    test_name = "random";
    for (int n = 0; n < 20; n++) send_pair(rand_instr(0, 7), rand_instr(0, 7));
    drain();
    repeat (10) cycle_step();

    test_name = "credits";
    check("pulses", 64'(pairs_sent), 64'(credit_pulses));
    check("fetch", 64'(`PAIR_QUEUE_DEPTH), 64'(fetch_credits));
    report_counts();
    if (mismatches == 0 && other_errors == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
issue_lane_if.sv
pair_queue.sv
issue_stage.sv
register_file.sv
execute_stage.sv
result_sender.sv
issue_core.sv
issue_core_chk.sv
issue_core_tb.sv

//--- run.sh
#!/bin/sh
# Compiles the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module issue_core_tb --Mdir obj_dir -o issue_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/issue_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
exit 1
